//--- common/rp_pkg.sv
// shared definitions for the analog board top level
// sample and bus types, route select, housekeeping register map and ID

package rp_pkg;

  //////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////

  // raw converter code, offset with negative slope
  typedef logic        [13:0] adc_raw_t;
  typedef logic signed [13:0] sample_t;   // two's complement sample

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [2:0]  region_t;          // address bits 22..20

  localparam int NUM_REGIONS = 8;         // fixed by address map

  //////////////////////////////////////////////////
  // output channel source select
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ROUTE_OWN   = 2'd0,                   // same channel adc sample
    ROUTE_OTHER = 2'd1,                   // opposite channel sample
    ROUTE_CONST = 2'd2,                   // programmed constant
    ROUTE_ZERO  = 2'd3                    // signed zero
  } route_sel_e;

  //////////////////////////////////////////////////
  // housekeeping register offsets, low 20 bits
  //////////////////////////////////////////////////

  localparam logic [19:0] HK_ID_OFS      = 20'h00000;  // read only
  localparam logic [19:0] HK_LOOP_OFS    = 20'h00004;  // bit 0 digital loop
  localparam logic [19:0] HK_ROUTE_OFS   = 20'h00008;  // [1:0] ch a, [3:2] ch b
  localparam logic [19:0] HK_CONST_A_OFS = 20'h0000C;  // 14 bit constant
  localparam logic [19:0] HK_CONST_B_OFS = 20'h00010;

  // identification word read back from the ID register
  localparam bus_data_t RP_ID = 32'h5250_0001;

endpackage

//--- rtl/sys_bus_decode.sv
// system bus region decoder
// splits the address space into eight regions on bits 22..20, steers the
// strobes to housekeeping and answers empty regions at once with zero data

module sys_bus_decode #(
  parameter int unsigned HK_REGION = 0    // region of the housekeeping block
) (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // bus from the master
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  logic              sys_wen_i,    // one cycle pulse
  input  logic              sys_ren_i,    // one cycle pulse
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  // housekeeping slave
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  input  rp_pkg::bus_data_t hk_rdata_i,
  input  logic              hk_ack_i
);

  rp_pkg::region_t                  region;
  logic [rp_pkg::NUM_REGIONS-1:0]   region_cs;   // one hot chip select
  logic                             hk_sel;

  //////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////

  assign region = sys_addr_i[22:20];

  always_comb
  begin
    region_cs         = '0;
    region_cs[region] = 1'b1;
  end

  assign hk_sel = region_cs[HK_REGION];   // address held until ack

  //////////////////////////////////////////////////
  // strobes, read mux, acknowledge
  //////////////////////////////////////////////////

  assign hk_wen_o = sys_wen_i & hk_sel;
  assign hk_ren_o = sys_ren_i & hk_sel;

  // empty regions read as zero
  assign sys_rdata_o = hk_sel ? hk_rdata_i : '0;

  // housekeeping acks one cycle later, empty regions in the strobe cycle
  assign sys_ack_o = hk_sel ? hk_ack_i : (sys_wen_i | sys_ren_i);

endmodule

//--- housekeeping/rp_housekeeping.sv
// housekeeping register file
// holds ID, digital loop bit, per channel route selects and channel
// constants; one cycle registered acknowledge for reads and writes

module rp_housekeeping (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  // system bus, region already decoded
  input  rp_pkg::bus_addr_t  addr_i,
  input  rp_pkg::bus_data_t  wdata_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output rp_pkg::bus_data_t  rdata_o,
  output logic               ack_o,
  // settings for the analog path
  output logic               loop_en_o,
  output rp_pkg::route_sel_e route_a_o,
  output rp_pkg::route_sel_e route_b_o,
  output rp_pkg::sample_t    const_a_o,
  output rp_pkg::sample_t    const_b_o
);

  logic [19:0] ofs;                        // offset inside the region

  assign ofs = addr_i[19:0];

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_en_o <= 1'b0;
      route_a_o <= rp_pkg::ROUTE_OWN;
      route_b_o <= rp_pkg::ROUTE_OWN;
      const_a_o <= '0;
      const_b_o <= '0;
    end
    else if (wen_i)
    begin
      case (ofs)
        rp_pkg::HK_LOOP_OFS:
          loop_en_o <= wdata_i[0];
        rp_pkg::HK_ROUTE_OFS:
        begin
          route_a_o <= rp_pkg::route_sel_e'(wdata_i[1:0]);
          route_b_o <= rp_pkg::route_sel_e'(wdata_i[3:2]);
        end
        rp_pkg::HK_CONST_A_OFS:
          const_a_o <= wdata_i[13:0];
        rp_pkg::HK_CONST_B_OFS:
          const_b_o <= wdata_i[13:0];
        default: ;                         // ID and holes are read only
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read data and acknowledge
  //////////////////////////////////////////////////

  // ack one cycle after either strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;
  end

  // read word captured on the strobe, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (ofs)
        rp_pkg::HK_ID_OFS:      rdata_o <= rp_pkg::RP_ID;
        rp_pkg::HK_LOOP_OFS:    rdata_o <= {31'h0, loop_en_o};
        rp_pkg::HK_ROUTE_OFS:   rdata_o <= {28'h0, route_b_o, route_a_o};
        rp_pkg::HK_CONST_A_OFS: rdata_o <= {18'h0, const_a_o};  // zero extended
        rp_pkg::HK_CONST_B_OFS: rdata_o <= {18'h0, const_b_o};
        default:                rdata_o <= '0;                  // unmapped
      endcase
    end
  end

endmodule

//--- analog/adc_frontend.sv
// ADC front end
// registers both converter channels, drops the two reserved bits and turns
// the negative slope offset code into two's complement; digital loop mux after

module adc_frontend (
  input  logic            adc_clk,
  input  logic            arst_n_i,
  input  logic [15:0]     adc_dat_a_i,   // bits 1:0 reserved
  input  logic [15:0]     adc_dat_b_i,
  input  logic            loop_en_i,     // feed dac samples back
  input  rp_pkg::sample_t loop_a_i,
  input  rp_pkg::sample_t loop_b_i,
  output rp_pkg::sample_t adc_a_o,
  output rp_pkg::sample_t adc_b_o
);

  rp_pkg::adc_raw_t adc_raw_a;
  rp_pkg::adc_raw_t adc_raw_b;
  rp_pkg::sample_t  adc_cnv_a;
  rp_pkg::sample_t  adc_cnv_b;

  // input register, reset code 0x1fff is signed zero
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_raw_a <= 14'h1FFF;
      adc_raw_b <= 14'h1FFF;
    end
    else
    begin
      adc_raw_a <= adc_dat_a_i[15:2];
      adc_raw_b <= adc_dat_b_i[15:2];
    end
  end

  // keep msb, invert the rest
  assign adc_cnv_a = {adc_raw_a[13], ~adc_raw_a[12:0]};
  assign adc_cnv_b = {adc_raw_b[13], ~adc_raw_b[12:0]};

  // digital loop substitutes the route outputs
  assign adc_a_o = loop_en_i ? loop_a_i : adc_cnv_a;
  assign adc_b_o = loop_en_i ? loop_b_i : adc_cnv_b;

endmodule

//--- analog/dac_backend.sv
// DAC back end
// output register for both channels with the signed to offset negative
// slope code conversion of the converter

module dac_backend (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  input  rp_pkg::sample_t  dac_a_i,
  input  rp_pkg::sample_t  dac_b_i,
  output rp_pkg::adc_raw_t dac_dat_a_o,   // to the converter pins
  output rp_pkg::adc_raw_t dac_dat_b_o
);

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // same msb kept, low 13 bits inverted mapping as on the adc side
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= 14'h1FFF;            // mid scale, signed zero
      dac_dat_b_o <= 14'h1FFF;
    end
    else
    begin
      dac_dat_a_o <= {dac_a_i[13], ~dac_a_i[12:0]};
      dac_dat_b_o <= {dac_b_i[13], ~dac_b_i[12:0]};
    end
  end

endmodule

//--- rtl/dsp_route.sv
// routing stage in place of the DSP block
// each output channel registers its own ADC sample, the other channel's
// sample, its programmed constant or zero

module dsp_route (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  input  rp_pkg::sample_t    adc_a_i,
  input  rp_pkg::sample_t    adc_b_i,
  input  rp_pkg::route_sel_e route_a_i,   // source for channel a
  input  rp_pkg::route_sel_e route_b_i,   // source for channel b
  input  rp_pkg::sample_t    const_a_i,
  input  rp_pkg::sample_t    const_b_i,
  output rp_pkg::sample_t    dat_a_o,
  output rp_pkg::sample_t    dat_b_o
);

  // source pick, shared by both channels
  function automatic rp_pkg::sample_t pick_src(
    input rp_pkg::route_sel_e sel,
    input rp_pkg::sample_t    own,
    input rp_pkg::sample_t    other,
    input rp_pkg::sample_t    cnst
  );
    rp_pkg::sample_t res;
    case (sel)
      rp_pkg::ROUTE_OWN:   res = own;
      rp_pkg::ROUTE_OTHER: res = other;
      rp_pkg::ROUTE_CONST: res = cnst;
      default:             res = '0;     // ROUTE_ZERO
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // one registered stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dat_a_o <= '0;
      dat_b_o <= '0;
    end
    else
    begin
      dat_a_o <= pick_src(route_a_i, adc_a_i, adc_b_i, const_a_i);
      dat_b_o <= pick_src(route_b_i, adc_b_i, adc_a_i, const_b_i);
    end
  end

endmodule

//--- rtl/rp_top.sv
// board top level, analog sample path under system bus control
// bus decoder and housekeeping registers drive ADC front end, route stage
// and DAC back end, all on adc_clk

module rp_top #(
  parameter int unsigned HK_REGION = 0    // housekeeping region, 0..7
) (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // converters
  input  logic [15:0]       adc_dat_a_i,
  input  logic [15:0]       adc_dat_b_i,
  output rp_pkg::adc_raw_t  dac_dat_a_o,
  output rp_pkg::adc_raw_t  dac_dat_b_o,
  // system bus
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o
);

  // decoder to housekeeping
  logic               hk_wen;
  logic               hk_ren;
  rp_pkg::bus_data_t  hk_rdata;
  logic               hk_ack;

  // settings
  logic               loop_en;
  rp_pkg::route_sel_e route_a, route_b;
  rp_pkg::sample_t    const_a, const_b;

  // sample path
  rp_pkg::sample_t    adc_a, adc_b;
  rp_pkg::sample_t    dac_a, dac_b;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  sys_bus_decode #(
    .HK_REGION (HK_REGION)
  ) u_sys_bus_decode (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack)
  );

  rp_housekeeping u_rp_housekeeping (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .addr_i    (sys_addr_i),
    .wdata_i   (sys_wdata_i),
    .wen_i     (hk_wen),
    .ren_i     (hk_ren),
    .rdata_o   (hk_rdata),
    .ack_o     (hk_ack),
    .loop_en_o (loop_en),
    .route_a_o (route_a),
    .route_b_o (route_b),
    .const_a_o (const_a),
    .const_b_o (const_b)
  );

  //////////////////////////////////////////////////
  // analog path, adc -> route -> dac
  //////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_a_i    (dac_a),                 // digital loop return
    .loop_b_i    (dac_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  dsp_route u_dsp_route (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .route_a_i (route_a),
    .route_b_i (route_b),
    .const_a_i (const_a),
    .const_b_i (const_b),
    .dat_a_o   (dac_a),
    .dat_b_o   (dac_b)
  );

  dac_backend u_dac_backend (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

//--- tests/rp_props.sv
// bus decoder properties
// empty region acks carry zero data, strobes stay out of foreign regions,
// never both strobes at once

module rp_props #(
  parameter int unsigned HK_REGION = 0
) (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  input  rp_pkg::bus_data_t sys_rdata_o,
  input  logic              sys_ack_o,
  input  logic              hk_wen_o,
  input  logic              hk_ren_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        empty_region;             // address outside housekeeping
  int unsigned ack_fails    = 0;
  int unsigned gate_fails   = 0;
  int unsigned strobe_fails = 0;

  assign empty_region = sys_addr_i[22:20] != 3'(HK_REGION);

  a_empty_ack_zero: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (sys_ack_o && empty_region) |-> (sys_rdata_o == '0))
    else
    begin
      $error("empty region acknowledged with nonzero read data");
      ack_fails++;
    end

  a_strobe_gated: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    empty_region |-> !(hk_wen_o || hk_ren_o))
    else
    begin
      $error("housekeeping strobe outside its region");
      gate_fails++;
    end

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i))
    else
    begin
      $error("write and read strobe high together");
      strobe_fails++;
    end

endmodule

bind sys_bus_decode rp_props #(
  .HK_REGION (HK_REGION)
) u_rp_props (
  .adc_clk     (adc_clk),
  .arst_n_i    (arst_n_i),
  .sys_addr_i  (sys_addr_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_o (sys_rdata_o),
  .sys_ack_o   (sys_ack_o),
  .hk_wen_o    (hk_wen_o),
  .hk_ren_o    (hk_ren_o)
);

//--- tests/rp_checker.sv
// reference model and comparison for the analog board top level
// three model stages plus shadow registers; checks DAC pins every cycle,
// ack timing on every access and read data on every read ack

module rp_checker #(
  parameter int unsigned HK_REGION = 0
) (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic [15:0]       adc_dat_a_i,
  input  logic [15:0]       adc_dat_b_i,
  input  rp_pkg::adc_raw_t  dac_dat_a_i,
  input  rp_pkg::adc_raw_t  dac_dat_b_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  input  rp_pkg::bus_data_t sys_rdata_i,
  input  logic              sys_ack_i,
  output int                err_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  rp_pkg::adc_raw_t  m_raw_a, m_raw_b;     // input register stage
  rp_pkg::sample_t   m_dat_a, m_dat_b;     // route stage
  rp_pkg::adc_raw_t  m_dac_a, m_dac_b;     // output register stage
  logic              sh_loop;
  logic [1:0]        sh_route_a, sh_route_b;
  rp_pkg::sample_t   sh_const_a, sh_const_b;
  logic              hk_pend, rd_pend;     // housekeeping ack due next edge
  rp_pkg::bus_data_t rd_exp;
  logic              hit, exp_ack;
  rp_pkg::sample_t   src_a, src_b;

  // offset code, 0x1fff is zero, slope negative
  function automatic rp_pkg::sample_t code_to_sample(input rp_pkg::adc_raw_t code);
    return rp_pkg::sample_t'(14'h1FFF - code);
  endfunction

  function automatic rp_pkg::adc_raw_t sample_to_code(input rp_pkg::sample_t smp);
    return rp_pkg::adc_raw_t'(14'h1FFF - smp);
  endfunction

  function automatic rp_pkg::sample_t route_source(input logic [1:0] sel,
    input rp_pkg::sample_t own, input rp_pkg::sample_t other, input rp_pkg::sample_t cnst);
    case (sel)
      rp_pkg::ROUTE_OWN:   return own;
      rp_pkg::ROUTE_OTHER: return other;
      rp_pkg::ROUTE_CONST: return cnst;
      default:             return '0;
    endcase
  endfunction

  // readback word from the shadow copies
  function automatic rp_pkg::bus_data_t reg_value(input logic [19:0] ofs);
    case (ofs)
      rp_pkg::HK_ID_OFS:      return rp_pkg::RP_ID;
      rp_pkg::HK_LOOP_OFS:    return {31'd0, sh_loop};
      rp_pkg::HK_ROUTE_OFS:   return {28'd0, sh_route_b, sh_route_a};
      rp_pkg::HK_CONST_A_OFS: return {18'd0, sh_const_a};
      rp_pkg::HK_CONST_B_OFS: return {18'd0, sh_const_b};
      default:                return '0;
    endcase
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] got,
    input logic [31:0] exp);
    err_cnt_o++;
    $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  //////////////////////////////////////////////////
  // compare, then advance the model
  //////////////////////////////////////////////////

  always @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      m_raw_a    = 14'h1FFF;
      m_raw_b    = 14'h1FFF;
      m_dat_a    = '0;
      m_dat_b    = '0;
      m_dac_a    = 14'h1FFF;               // signed zero on the pins
      m_dac_b    = 14'h1FFF;
      sh_loop    = 1'b0;
      sh_route_a = rp_pkg::ROUTE_OWN;
      sh_route_b = rp_pkg::ROUTE_OWN;
      sh_const_a = '0;
      sh_const_b = '0;
      hk_pend    = 1'b0;
      rd_pend    = 1'b0;
      rd_exp     = '0;
      err_cnt_o  = 0;
    end
    else
    begin
      hit = sys_addr_i[22:20] == 3'(HK_REGION);
      if (dac_dat_a_i !== m_dac_a)
        flag_mismatch("dac_dat_a_o", 32'(dac_dat_a_i), 32'(m_dac_a));
      if (dac_dat_b_i !== m_dac_b)
        flag_mismatch("dac_dat_b_o", 32'(dac_dat_b_i), 32'(m_dac_b));
      // empty regions ack in the strobe cycle, housekeeping one later
      exp_ack = ((sys_wen_i | sys_ren_i) & !hit) | hk_pend;
      if (sys_ack_i !== exp_ack)
        flag_mismatch("sys_ack_o", 32'(sys_ack_i), 32'(exp_ack));
      if (sys_ren_i && !hit && sys_rdata_i !== '0)
        flag_mismatch("empty region sys_rdata_o", sys_rdata_i, 32'd0);
      if (rd_pend && sys_rdata_i !== rd_exp)
        flag_mismatch("sys_rdata_o", sys_rdata_i, rd_exp);
      hk_pend = (sys_wen_i | sys_ren_i) & hit;
      rd_pend = sys_ren_i & hit;
      if (rd_pend)
        rd_exp = reg_value(sys_addr_i[19:0]);
      // pipeline, old settings apply at this edge
      src_a   = sh_loop ? m_dat_a : code_to_sample(m_raw_a);
      src_b   = sh_loop ? m_dat_b : code_to_sample(m_raw_b);
      m_dac_a = sample_to_code(m_dat_a);
      m_dac_b = sample_to_code(m_dat_b);
      m_dat_a = route_source(sh_route_a, src_a, src_b, sh_const_a);
      m_dat_b = route_source(sh_route_b, src_b, src_a, sh_const_b);
      m_raw_a = adc_dat_a_i[15:2];         // reserved bits dropped
      m_raw_b = adc_dat_b_i[15:2];
      if (sys_wen_i && hit)
      begin
        case (sys_addr_i[19:0])
          rp_pkg::HK_LOOP_OFS:    sh_loop = sys_wdata_i[0];
          rp_pkg::HK_ROUTE_OFS:
          begin
            sh_route_a = sys_wdata_i[1:0];
            sh_route_b = sys_wdata_i[3:2];
          end
          rp_pkg::HK_CONST_A_OFS: sh_const_a = sys_wdata_i[13:0];
          rp_pkg::HK_CONST_B_OFS: sh_const_b = sys_wdata_i[13:0];
          default: ;
        endcase
      end
    end
  end

endmodule

//--- tests/tb_rp_top.sv
// testbench for the analog board top level
// clock, reset, seeded random bus and ADC stimulus, watchdog and summary;
// all comparing happens in the checker and the bound decoder properties

module tb_rp_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned HK_REGION  = 0;
  localparam int          CLK_PERIOD = 4;
  localparam int          MAX_CYCLES = 2000;   // covers all five tests
  localparam int          ACK_WAIT   = 8;

  logic              adc_clk;
  logic              arst_n_i;
  logic [15:0]       adc_dat_a, adc_dat_b;
  rp_pkg::adc_raw_t  dac_dat_a, dac_dat_b;
  rp_pkg::bus_addr_t sys_addr;
  rp_pkg::bus_data_t sys_wdata, sys_rdata;
  logic              sys_wen, sys_ren, sys_ack;
  int                chk_errors;
  int                bus_errors   = 0;
  int                failed_tests = 0;

  rp_top #(
    .HK_REGION (HK_REGION)
  ) u_rp_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack)
  );

  rp_checker #(
    .HK_REGION (HK_REGION)
  ) u_rp_checker (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_i (dac_dat_a),
    .dac_dat_b_i (dac_dat_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_i (sys_rdata),
    .sys_ack_i   (sys_ack),
    .err_cnt_o   (chk_errors)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // hard stop if an access or the test sequence hangs
  initial
  begin
    #(MAX_CYCLES * CLK_PERIOD + 200);
    $display("watchdog expired before the test sequence finished");
    $display("tests failed");
    $finish;
  end

  function automatic int total_errors();
    return chk_errors + bus_errors
      + int'(u_rp_top.u_sys_bus_decode.u_rp_props.ack_fails)
      + int'(u_rp_top.u_sys_bus_decode.u_rp_props.gate_fails)
      + int'(u_rp_top.u_sys_bus_decode.u_rp_props.strobe_fails);
  endfunction

  function automatic rp_pkg::bus_addr_t hk_addr(input logic [19:0] ofs);
    return {9'h000, 3'(HK_REGION), ofs};
  endfunction

  //////////////////////////////////////////////////
  // bus and sample drivers on the falling edge
  //////////////////////////////////////////////////

  // one strobe cycle with the address held until the ack
  task automatic bus_access(input logic write, input rp_pkg::bus_addr_t addr,
    input rp_pkg::bus_data_t data);
    int  waited;
    logic acked;
    @(negedge adc_clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = write;
    sys_ren   = !write;
    @(negedge adc_clk);
    acked   = sys_ack;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    waited  = 0;
    while (!acked && waited < ACK_WAIT)
    begin
      @(negedge adc_clk);
      acked = sys_ack;
      waited++;
    end
    if (!acked)
    begin
      bus_errors++;
      $display("bus access to address %h was never acknowledged", addr);
    end
  endtask

  task automatic hk_write(input logic [19:0] ofs, input rp_pkg::bus_data_t data);
    bus_access(1'b1, hk_addr(ofs), data);
  endtask

  task automatic hk_read(input logic [19:0] ofs);
    bus_access(1'b0, hk_addr(ofs), '0);
  endtask

  task automatic drive_random_adc(input int cycles);
    repeat (cycles)
    begin
      @(negedge adc_clk);
      adc_dat_a = 16'($urandom);
      adc_dat_b = 16'($urandom);
    end
  endtask

  task automatic end_test(input int num, input string name, input int start);
    int errs;
    errs = total_errors() - start;
    if (errs != 0)
      failed_tests++;
    $display("test %0d %s: %0d errors", num, name, errs);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int                start;
    logic [19:0]       ofs;
    logic [2:0]        region;
    logic [1:0]        rb;
    void'($urandom(49));
    arst_n_i  = 1'b0;
    adc_dat_a = 16'h7FFC;                  // raw 0x1fff is signed zero
    adc_dat_b = 16'h7FFC;
    sys_addr  = hk_addr(rp_pkg::HK_ID_OFS);
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    repeat (5) @(posedge adc_clk);         // five rising edges in reset
    @(negedge adc_clk);
    arst_n_i = 1'b1;

    // pins idle at mid scale until the first random sample arrives
    start = total_errors();
    drive_random_adc(1);
    repeat (6) @(negedge adc_clk);
    hk_read(rp_pkg::HK_ID_OFS);
    hk_read(rp_pkg::HK_LOOP_OFS);
    end_test(1, "reset state", start);

    // random register writes including ID and holes
    start = total_errors();
    for (int i = 0; i < 24; i++)
    begin
      case ($urandom % 6)
        0:       ofs = rp_pkg::HK_LOOP_OFS;
        1:       ofs = rp_pkg::HK_ROUTE_OFS;
        2:       ofs = rp_pkg::HK_CONST_A_OFS;
        3:       ofs = rp_pkg::HK_CONST_B_OFS;
        4:       ofs = rp_pkg::HK_ID_OFS;
        default: ofs = 20'h00014 + 20'(($urandom % 64) * 4);
      endcase
      hk_write(ofs, $urandom);
      hk_read(ofs);
    end
    end_test(2, "register readback", start);

    // foreign region accesses leave the mapped offsets untouched
    start = total_errors();
    repeat (12)
    begin
      region = 3'((HK_REGION + 1 + $urandom % 7) % 8);
      ofs    = 20'(($urandom % 5) * 4);
      bus_access(1'b1, {9'h000, region, ofs}, $urandom);
      bus_access(1'b0, {9'h000, region, ofs}, '0);
      hk_read(ofs);
    end
    end_test(3, "empty regions", start);

    // open loop with every route value on both channels
    start = total_errors();
    hk_write(rp_pkg::HK_LOOP_OFS, 32'd0);
    hk_write(rp_pkg::HK_CONST_A_OFS, $urandom);
    hk_write(rp_pkg::HK_CONST_B_OFS, $urandom);
    for (int r = 0; r < 8; r++)
    begin
      rb = (r < 4) ? 2'(3 - r) : 2'($urandom);
      hk_write(rp_pkg::HK_ROUTE_OFS, {28'd0, rb, 2'(r)});
      drive_random_adc(30);
    end
    end_test(4, "sample path", start);

    // digital loop where a holds its constant and b copies a
    start = total_errors();
    hk_write(rp_pkg::HK_CONST_A_OFS, $urandom);
    hk_write(rp_pkg::HK_ROUTE_OFS, {28'd0, rp_pkg::ROUTE_OTHER, rp_pkg::ROUTE_CONST});
    hk_write(rp_pkg::HK_LOOP_OFS, 32'd1);
    drive_random_adc(40);
    hk_read(rp_pkg::HK_LOOP_OFS);
    hk_write(rp_pkg::HK_LOOP_OFS, 32'd0);
    repeat (5) @(negedge adc_clk);
    end_test(5, "digital loop", start);

    $display("summary: 5 tests, %0d failing, %0d errors", failed_tests, total_errors());
    if (failed_tests == 0 && total_errors() == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- rp_top.f
common/rp_pkg.sv
rtl/sys_bus_decode.sv
housekeeping/rp_housekeeping.sv
analog/adc_frontend.sv
analog/dac_backend.sv
rtl/dsp_route.sv
rtl/rp_top.sv
tests/rp_props.sv
tests/rp_checker.sv
tests/tb_rp_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rp_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rp_top -f rp_top.f

# an early stop still prints what ran; the pass line decides
out="$(./obj_dir/Vtb_rp_top || true)"
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
